//--- alu.sv
// Integer ALU with compare flags for the branch unit
// Shifts use shamt only, b is ignored for sll and sra
module alu import cpu_pkg::*; (
	input  logic [XLEN-1:0]  a,
	input  logic [XLEN-1:0]  b,
	input  alu_op_e          op,
	input  logic [REG_W-1:0] shamt,
	output logic [XLEN-1:0]  result,
	output logic             not_equal,
	output logic             less_than
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLL: result = a << shamt;
			ALU_SRA: result = $signed(a) >>> shamt;  // Arithmetic
			default: result = '0;
		endcase
	end

	assign not_equal = (a != b);
	assign less_than = ($signed(a) < $signed(b));

endmodule

//--- cpu_pkg.sv
// Widths, instruction fields and encodings shared by the five-stage core
// Immediates are 17 bits sign-extended and jump targets 27 bits zero-extended
package cpu_pkg;

	localparam int XLEN  = 32;
	localparam int REG_W = 5;
	localparam logic [REG_W-1:0] RA_REG = 5'd31;  // Link register for jal

	// Instruction field positions
	localparam int OPC_HI   = 31;
	localparam int OPC_LO   = 27;
	localparam int RD_HI    = 26;
	localparam int RD_LO    = 22;
	localparam int RS_HI    = 21;
	localparam int RS_LO    = 17;
	localparam int RT_HI    = 16;
	localparam int RT_LO    = 12;
	localparam int SHAMT_HI = 11;
	localparam int SHAMT_LO = 7;
	localparam int ALUOP_HI = 6;
	localparam int ALUOP_LO = 2;
	localparam int IMM_HI   = 16;  // Sign bit of the immediate
	localparam int IMM_LO   = 0;
	localparam int TGT_HI   = 26;
	localparam int TGT_LO   = 0;

	typedef enum logic [4:0] {
		OP_RTYPE = 5'd0,
		OP_J     = 5'd1,
		OP_BNE   = 5'd2,
		OP_JAL   = 5'd3,
		OP_JR    = 5'd4,
		OP_ADDI  = 5'd5,
		OP_BLT   = 5'd6,
		OP_SW    = 5'd7,
		OP_LW    = 5'd8
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_AND = 5'd2,
		ALU_OR  = 5'd3,
		ALU_SLL = 5'd4,
		ALU_SRA = 5'd5
	} alu_op_e;

	typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

	localparam logic [XLEN-1:0] NOP = '0;  // add r0, r0, r0

endpackage

//--- decode_stage.sv
// F/D and D/X registers with register-file read and destination decode
// The register file writes at the clock edge, so writeback data is bypassed here
module decode_stage import cpu_pkg::*; #(
	parameter int PC_W = 16
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             stall,
	input  logic             flush,
	input  logic [XLEN-1:0]  q_imem,
	input  logic [XLEN-1:0]  data_read_reg_a,
	input  logic [XLEN-1:0]  data_read_reg_b,
	input  logic [PC_W-1:0]  pc_next,
	input  logic             w_writes,
	input  logic [REG_W-1:0] w_dest,
	input  logic [XLEN-1:0]  w_data,
	output logic [REG_W-1:0] ctrl_read_reg_a,
	output logic [REG_W-1:0] ctrl_read_reg_b,
	output logic [REG_W-1:0] d_src_a,
	output logic [REG_W-1:0] d_src_b,
	output logic             d_uses_a,
	output logic             d_uses_b,
	output logic [XLEN-1:0]  x_instr,
	output logic [XLEN-1:0]  x_a,
	output logic [XLEN-1:0]  x_b,
	output logic [PC_W-1:0]  x_pc_next,
	output logic [REG_W-1:0] x_src_a,
	output logic [REG_W-1:0] x_src_b,
	output logic [REG_W-1:0] x_dest,
	output logic             x_writes,
	output logic             x_is_load
);

	logic [XLEN-1:0]  fd_instr;
	logic [PC_W-1:0]  fd_pc_next;
	opcode_e          opc;
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] rs;
	logic [REG_W-1:0] rt;
	logic [XLEN-1:0]  a_val;
	logic [XLEN-1:0]  b_val;
	logic [REG_W-1:0] dest;
	logic             writes;

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			fd_instr <= NOP;
		end else if (!stall) begin
			fd_instr <= q_imem;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			fd_pc_next <= pc_next;
		end
	end

	assign opc = opcode_e'(fd_instr[OPC_HI:OPC_LO]);
	assign rd  = fd_instr[RD_HI:RD_LO];
	assign rs  = fd_instr[RS_HI:RS_LO];
	assign rt  = fd_instr[RT_HI:RT_LO];

	always_comb begin
		d_uses_a        = 1'b0;
		d_uses_b        = 1'b0;
		ctrl_read_reg_b = rd;  // Store data, branch compare, jr target
		case (opc)
			OP_RTYPE: begin
				ctrl_read_reg_b = rt;
				d_uses_a        = 1'b1;
				d_uses_b        = 1'b1;
			end
			OP_ADDI, OP_LW: d_uses_a = 1'b1;
			OP_SW, OP_BNE, OP_BLT: begin
				d_uses_a = 1'b1;
				d_uses_b = 1'b1;
			end
			OP_JR: d_uses_b = 1'b1;
			default: ;
		endcase
	end

	assign ctrl_read_reg_a = rs;
	assign d_src_a = d_uses_a ? rs : '0;
	assign d_src_b = d_uses_b ? ctrl_read_reg_b : '0;

	assign a_val = (w_writes && w_dest != '0 && w_dest == rs) ? w_data : data_read_reg_a;
	assign b_val = (w_writes && w_dest != '0 && w_dest == ctrl_read_reg_b) ?
		w_data : data_read_reg_b;

	// sw keeps rd here too, the memory stage needs it for its bypass
	assign dest = (opc == OP_JAL) ? RA_REG : rd;

	always_comb begin
		case (opc)
			OP_RTYPE, OP_ADDI, OP_LW, OP_JAL: writes = (dest != '0);
			default: writes = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n || stall || flush) begin
			x_instr   <= NOP;  // Bubble
			x_src_a   <= '0;
			x_src_b   <= '0;
			x_dest    <= '0;
			x_writes  <= 1'b0;
			x_is_load <= 1'b0;
		end else begin
			x_instr   <= fd_instr;
			x_src_a   <= d_src_a;
			x_src_b   <= d_src_b;
			x_dest    <= dest;
			x_writes  <= writes;
			x_is_load <= (opc == OP_LW);
		end
	end

	always_ff @(posedge clock) begin
		x_a       <= a_val;
		x_b       <= b_val;
		x_pc_next <= fd_pc_next;
	end

endmodule

//--- execute_stage.sv
// Execute stage: operand forwarding, ALU, branch and jump resolution, X/M register
// Branch and jump targets are truncated to the PC width
module execute_stage import cpu_pkg::*; #(
	parameter int PC_W = 16
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [XLEN-1:0]  x_instr,
	input  logic [XLEN-1:0]  x_a,
	input  logic [XLEN-1:0]  x_b,
	input  logic [PC_W-1:0]  x_pc_next,
	input  logic [REG_W-1:0] x_dest,
	input  logic             x_writes,
	input  logic             x_is_load,
	input  fwd_sel_e         fwd_a,
	input  fwd_sel_e         fwd_b,
	input  logic [XLEN-1:0]  w_data,
	output logic             redirect,
	output logic [PC_W-1:0]  redirect_pc,
	output logic [XLEN-1:0]  m_result,
	output logic [XLEN-1:0]  m_store,
	output logic [REG_W-1:0] m_dest,
	output logic             m_writes,
	output logic             m_is_load,
	output logic             m_is_store
);

	opcode_e         opc;
	alu_op_e         op;
	logic [XLEN-1:0] opnd_a;
	logic [XLEN-1:0] opnd_b;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] result;
	logic            use_imm;
	logic            is_branch;
	logic            not_equal;
	logic            less_than;

	function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
		input logic [XLEN-1:0] reg_val, input logic [XLEN-1:0] mem_val,
		input logic [XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign opc    = opcode_e'(x_instr[OPC_HI:OPC_LO]);
	assign opnd_a = fwd_mux(fwd_a, x_a, m_result, w_data);
	assign opnd_b = fwd_mux(fwd_b, x_b, m_result, w_data);

	assign imm    = {{(XLEN-IMM_HI-1){x_instr[IMM_HI]}}, x_instr[IMM_HI:IMM_LO]};
	assign target = XLEN'(x_instr[TGT_HI:TGT_LO]);

	assign use_imm   = opc inside {OP_ADDI, OP_LW, OP_SW};
	assign is_branch = opc inside {OP_BNE, OP_BLT};

	// Branches compare rd (port B) against rs (port A)
	assign alu_a = is_branch ? opnd_b : opnd_a;
	assign alu_b = use_imm ? imm : (is_branch ? opnd_a : opnd_b);
	assign op    = (opc == OP_RTYPE) ? alu_op_e'(x_instr[ALUOP_HI:ALUOP_LO]) : ALU_ADD;

	alu u_alu (
		.a         (alu_a),
		.b         (alu_b),
		.op        (op),
		.shamt     (x_instr[SHAMT_HI:SHAMT_LO]),
		.result    (alu_result),
		.not_equal (not_equal),
		.less_than (less_than)
	);

	always_comb begin
		redirect    = 1'b0;
		redirect_pc = x_pc_next + imm[PC_W-1:0];  // Relative to PC+1
		case (opc)
			OP_BNE: redirect = not_equal;
			OP_BLT: redirect = less_than;
			OP_J, OP_JAL: begin
				redirect    = 1'b1;
				redirect_pc = target[PC_W-1:0];
			end
			OP_JR: begin
				redirect    = 1'b1;
				redirect_pc = opnd_b[PC_W-1:0];
			end
			default: ;
		endcase
	end

	assign result = (opc == OP_JAL) ? XLEN'(x_pc_next) : alu_result;  // Return address

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			m_dest     <= '0;
			m_writes   <= 1'b0;
			m_is_load  <= 1'b0;
			m_is_store <= 1'b0;
		end else begin
			m_dest     <= x_dest;
			m_writes   <= x_writes;
			m_is_load  <= x_is_load;
			m_is_store <= (opc == OP_SW);
		end
	end

	always_ff @(posedge clock) begin
		m_result <= result;
		m_store  <= opnd_b;
	end

endmodule

//--- hazard_ctrl.sv
// Pipeline hazard control, purely combinational
// Sources that an instruction does not read arrive as r0 and never forward
module hazard_ctrl import cpu_pkg::*; (
	input  logic [REG_W-1:0] d_src_a,
	input  logic [REG_W-1:0] d_src_b,
	input  logic [REG_W-1:0] x_src_a,
	input  logic [REG_W-1:0] x_src_b,
	input  logic [REG_W-1:0] x_dest,
	input  logic [REG_W-1:0] m_dest,
	input  logic [REG_W-1:0] w_dest,
	input  logic             d_uses_a,
	input  logic             d_uses_b,
	input  logic             x_is_load,
	input  logic             m_writes,
	input  logic             w_writes,
	input  logic             redirect,
	output logic             stall,
	output fwd_sel_e         fwd_a,
	output fwd_sel_e         fwd_b,
	output logic             flush
);

	logic load_use;

	// Memory stage holds the younger result, so it is checked first
	function automatic fwd_sel_e pick_fwd(input logic [REG_W-1:0] src,
		input logic mw, input logic [REG_W-1:0] md,
		input logic ww, input logic [REG_W-1:0] wd);
		fwd_sel_e sel;
		sel = FWD_NONE;
		if (src != '0 && mw && md == src) begin
			sel = FWD_MEM;
		end else if (src != '0 && ww && wd == src) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fwd_a = pick_fwd(x_src_a, m_writes, m_dest, w_writes, w_dest);
	assign fwd_b = pick_fwd(x_src_b, m_writes, m_dest, w_writes, w_dest);

	// Load result is not ready until writeback
	assign load_use = x_is_load && x_dest != '0 &&
		((d_uses_a && d_src_a == x_dest) || (d_uses_b && d_src_b == x_dest));

	assign flush = redirect;
	assign stall = load_use && !redirect;  // Flush wins

endmodule

//--- mem_wb_stage.sv
// Memory access, M/W register and writeback port
// Data memory reads are combinational and writes land on the next edge
module mem_wb_stage import cpu_pkg::*; (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [XLEN-1:0]  m_result,
	input  logic [XLEN-1:0]  m_store,
	input  logic [REG_W-1:0] m_dest,
	input  logic             m_writes,
	input  logic             m_is_load,
	input  logic             m_is_store,
	input  logic [XLEN-1:0]  q_dmem,
	output logic [XLEN-1:0]  address_dmem,
	output logic [XLEN-1:0]  data,
	output logic             wren,
	output logic             reg_write_en,
	output logic [REG_W-1:0] reg_write_addr,
	output logic [XLEN-1:0]  reg_write_data
);

	logic store_bypass;

	assign address_dmem = m_result;
	assign wren         = m_is_store;

	// For sw, m_dest names the register being stored
	assign store_bypass = m_is_store && reg_write_en && reg_write_addr == m_dest;
	assign data         = store_bypass ? reg_write_data : m_store;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			reg_write_en   <= 1'b0;
			reg_write_addr <= '0;
		end else begin
			reg_write_en   <= m_writes;
			reg_write_addr <= m_dest;
		end
	end

	always_ff @(posedge clock) begin
		reg_write_data <= m_is_load ? q_dmem : m_result;
	end

endmodule

//--- pc_counter.sv
// Fetch program counter, word addressed
// A redirect from execute wins over a load-use stall
module pc_counter import cpu_pkg::*; #(
	parameter int PC_W = 16
) (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            stall,
	input  logic            redirect,
	input  logic [PC_W-1:0] redirect_pc,
	output logic [PC_W-1:0] pc,
	output logic [PC_W-1:0] pc_next,
	output logic [XLEN-1:0] address_imem
);

	assign pc_next      = pc + 1'b1;
	assign address_imem = XLEN'(pc);  // Zero-extended onto the imem bus

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;  // Taken branch or jump
		end else if (!stall) begin
			pc <= pc_next;
		end
	end

endmodule

//--- processor.sv
// Five-stage pipelined core, memories and register file sit outside
// Imem, dmem and register-file reads must return data in the same cycle
module processor import cpu_pkg::*; #(
	parameter int PC_W = 16
) (
	input  logic             clock,
	input  logic             rst_n,
	output logic [XLEN-1:0]  address_imem,
	input  logic [XLEN-1:0]  q_imem,
	output logic [XLEN-1:0]  address_dmem,
	output logic [XLEN-1:0]  data,
	output logic             wren,
	input  logic [XLEN-1:0]  q_dmem,
	output logic [REG_W-1:0] ctrl_read_reg_a,
	output logic [REG_W-1:0] ctrl_read_reg_b,
	input  logic [XLEN-1:0]  data_read_reg_a,
	input  logic [XLEN-1:0]  data_read_reg_b,
	output logic             reg_write_en,
	output logic [REG_W-1:0] reg_write_addr,
	output logic [XLEN-1:0]  reg_write_data
);

	logic [PC_W-1:0]  fetch_pc_next;
	logic             stall;
	logic             flush;
	logic             redirect;
	logic [PC_W-1:0]  redirect_pc;
	logic [REG_W-1:0] d_src_a;
	logic [REG_W-1:0] d_src_b;
	logic             d_uses_a;
	logic             d_uses_b;
	logic [XLEN-1:0]  x_instr;
	logic [XLEN-1:0]  x_a;
	logic [XLEN-1:0]  x_b;
	logic [PC_W-1:0]  x_pc_next;
	logic [REG_W-1:0] x_src_a;
	logic [REG_W-1:0] x_src_b;
	logic [REG_W-1:0] x_dest;
	logic             x_writes;
	logic             x_is_load;
	fwd_sel_e         fwd_a;
	fwd_sel_e         fwd_b;
	logic [XLEN-1:0]  m_result;
	logic [XLEN-1:0]  m_store;
	logic [REG_W-1:0] m_dest;
	logic             m_writes;
	logic             m_is_load;
	logic             m_is_store;

	pc_counter #(.PC_W(PC_W)) u_pc (
		.clock        (clock),
		.rst_n        (rst_n),
		.stall        (stall),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.pc           (),
		.pc_next      (fetch_pc_next),
		.address_imem (address_imem)
	);

	hazard_ctrl u_hazard (
		.d_src_a   (d_src_a),
		.d_src_b   (d_src_b),
		.x_src_a   (x_src_a),
		.x_src_b   (x_src_b),
		.x_dest    (x_dest),
		.m_dest    (m_dest),
		.w_dest    (reg_write_addr),
		.d_uses_a  (d_uses_a),
		.d_uses_b  (d_uses_b),
		.x_is_load (x_is_load),
		.m_writes  (m_writes),
		.w_writes  (reg_write_en),
		.redirect  (redirect),
		.stall     (stall),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.flush     (flush)
	);

	decode_stage #(.PC_W(PC_W)) u_decode (
		.clock           (clock),
		.rst_n           (rst_n),
		.stall           (stall),
		.flush           (flush),
		.q_imem          (q_imem),
		.data_read_reg_a (data_read_reg_a),
		.data_read_reg_b (data_read_reg_b),
		.pc_next         (fetch_pc_next),
		.w_writes        (reg_write_en),
		.w_dest          (reg_write_addr),
		.w_data          (reg_write_data),
		.ctrl_read_reg_a (ctrl_read_reg_a),
		.ctrl_read_reg_b (ctrl_read_reg_b),
		.d_src_a         (d_src_a),
		.d_src_b         (d_src_b),
		.d_uses_a        (d_uses_a),
		.d_uses_b        (d_uses_b),
		.x_instr         (x_instr),
		.x_a             (x_a),
		.x_b             (x_b),
		.x_pc_next       (x_pc_next),
		.x_src_a         (x_src_a),
		.x_src_b         (x_src_b),
		.x_dest          (x_dest),
		.x_writes        (x_writes),
		.x_is_load       (x_is_load)
	);

	execute_stage #(.PC_W(PC_W)) u_execute (
		.clock       (clock),
		.rst_n       (rst_n),
		.x_instr     (x_instr),
		.x_a         (x_a),
		.x_b         (x_b),
		.x_pc_next   (x_pc_next),
		.x_dest      (x_dest),
		.x_writes    (x_writes),
		.x_is_load   (x_is_load),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.w_data      (reg_write_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.m_result    (m_result),
		.m_store     (m_store),
		.m_dest      (m_dest),
		.m_writes    (m_writes),
		.m_is_load   (m_is_load),
		.m_is_store  (m_is_store)
	);

	mem_wb_stage u_mem_wb (
		.clock          (clock),
		.rst_n          (rst_n),
		.m_result       (m_result),
		.m_store        (m_store),
		.m_dest         (m_dest),
		.m_writes       (m_writes),
		.m_is_load      (m_is_load),
		.m_is_store     (m_is_store),
		.q_dmem         (q_dmem),
		.address_dmem   (address_dmem),
		.data           (data),
		.wren           (wren),
		.reg_write_en   (reg_write_en),
		.reg_write_addr (reg_write_addr),
		.reg_write_data (reg_write_data)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_processor -f sources.f \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_processor > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- sources.f
cpu_pkg.sv
alu.sv
pc_counter.sv
hazard_ctrl.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
processor.sv
tb_clock.sv
tb_processor.sv

//--- tb_clock.sv
// Testbench clock, starts low with the first rising edge after half a period
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clock
);

	initial clock = 1'b0;

	always #(PERIOD / 2) clock = ~clock;

endmodule

//--- tb_processor.sv
// Directed testbench for the five-stage core with imem, dmem and register-file models
// Programs start at word 0 and end in a self-loop j; unused imem words are self-loops too
// Expected writes come from an instruction-level model that runs the same program
module tb_processor import cpu_pkg::*; ();

	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 80;
	localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST;
	localparam int IDLE_LIMIT      = 20;  // Cycles without a new write event

	logic        clock;
	logic        rst_n;
	logic [31:0] address_imem;
	logic [31:0] q_imem;
	logic [31:0] address_dmem;
	logic [31:0] data;
	logic        wren;
	logic [31:0] q_dmem;
	logic [4:0]  ctrl_read_reg_a;
	logic [4:0]  ctrl_read_reg_b;
	logic [31:0] data_read_reg_a;
	logic [31:0] data_read_reg_b;
	logic        reg_write_en;
	logic [4:0]  reg_write_addr;
	logic [31:0] reg_write_data;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] rf   [32];
	logic [31:0] prog [64];  // Program being built, copied into imem
	int          prog_len;

	logic [4:0]  exp_reg_addr [$];
	logic [31:0] exp_reg_data [$];
	logic [31:0] exp_mem_addr [$];
	logic [31:0] exp_mem_data [$];
	int          reg_idx;
	int          mem_idx;
	int          test_errors;
	int          total_errors;
	int          tests_failed;
	int          cycle_count;
	logic [31:0] rng_state;

	tb_clock #(.PERIOD(4)) clk_i (.clock(clock));

	processor #(.PC_W(16)) dut_i (
		.clock           (clock),
		.rst_n           (rst_n),
		.address_imem    (address_imem),
		.q_imem          (q_imem),
		.address_dmem    (address_dmem),
		.data            (data),
		.wren            (wren),
		.q_dmem          (q_dmem),
		.ctrl_read_reg_a (ctrl_read_reg_a),
		.ctrl_read_reg_b (ctrl_read_reg_b),
		.data_read_reg_a (data_read_reg_a),
		.data_read_reg_b (data_read_reg_b),
		.reg_write_en    (reg_write_en),
		.reg_write_addr  (reg_write_addr),
		.reg_write_data  (reg_write_data)
	);

	// Combinational reads, word addressed, 64 words
	assign q_imem          = imem[address_imem[5:0]];
	assign q_dmem          = dmem[address_dmem[5:0]];
	assign data_read_reg_a = rf[ctrl_read_reg_a];
	assign data_read_reg_b = rf[ctrl_read_reg_b];

	always @(posedge clock) begin
		if (rst_n && reg_write_en && reg_write_addr != '0)
			rf[reg_write_addr] <= reg_write_data;  // r0 stays zero
		if (rst_n && wren)
			dmem[address_dmem[5:0]] <= data;
	end

	function automatic logic [31:0] enc_r(input int rd, input int rs, input int rt,
		input int shamt, input alu_op_e op);
		return {OP_RTYPE, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], op, 2'b00};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e opc, input int rd, input int rs,
		input int imm);
		return {opc, rd[4:0], rs[4:0], imm[16:0]};
	endfunction

	function automatic logic [31:0] enc_j(input opcode_e opc, input int target);
		return {opc, target[26:0]};
	endfunction

	function automatic logic [31:0] dmem_fill(input int i);
		logic [31:0] a;
		a = i;
		return 32'h3c00_0000 ^ (a * 32'h0001_0101);
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Instruction-level ALU for the reference model
	function automatic logic [31:0] expected_alu(input logic [4:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] sh);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_SLL: return a << sh;
			ALU_SRA: return $signed(a) >>> sh;
			default: return '0;
		endcase
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic emit_halt();
		emit(enc_j(OP_J, prog_len));  // Jumps to itself
	endtask

	task automatic clear_memories();
		for (int i = 0; i < 64; i++) begin
			imem[i] <= enc_j(OP_J, i);
			dmem[i] <= dmem_fill(i);
		end
		for (int i = 0; i < 32; i++)
			rf[i] <= '0;
	endtask

	// Runs prog from word 0 and queues every register and memory write in order
	task automatic run_reference();
		logic [31:0] mr [32];
		logic [31:0] md [64];
		logic [31:0] w;
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] wr_val;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic        wr_en;
		logic        halted;
		int          steps;
		for (int i = 0; i < 32; i++)
			mr[i] = '0;
		for (int i = 0; i < 64; i++)
			md[i] = dmem_fill(i);
		pc = '0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 200) begin
			w = prog[pc[5:0]];
			rd = w[26:22];
			rs = w[21:17];
			imm = {{15{w[16]}}, w[16:0]};
			next_pc = pc + 1;
			wr_en = 1'b0;
			wr_val = '0;
			case (w[31:27])
				OP_RTYPE: begin
					wr_en = 1'b1;
					wr_val = expected_alu(w[6:2], mr[rs], mr[w[16:12]], w[11:7]);
				end
				OP_ADDI: begin
					wr_en = 1'b1;
					wr_val = mr[rs] + imm;
				end
				OP_LW: begin
					addr = mr[rs] + imm;
					wr_en = 1'b1;
					wr_val = md[addr[5:0]];
				end
				OP_SW: begin
					addr = mr[rs] + imm;
					md[addr[5:0]] = mr[rd];
					exp_mem_addr.push_back(addr);
					exp_mem_data.push_back(mr[rd]);
				end
				OP_BNE: if (mr[rd] != mr[rs]) next_pc = pc + 1 + imm;
				OP_BLT: if ($signed(mr[rd]) < $signed(mr[rs])) next_pc = pc + 1 + imm;
				OP_J: begin
					halted = (w[26:0] == pc[26:0]);
					next_pc = {5'b0, w[26:0]};
				end
				OP_JAL: begin
					rd = 5'd31;
					wr_en = 1'b1;
					wr_val = pc + 1;
					next_pc = {5'b0, w[26:0]};
				end
				OP_JR: next_pc = mr[rd];
				default: ;
			endcase
			if (wr_en && rd != '0) begin
				mr[rd] = wr_val;
				exp_reg_addr.push_back(rd);
				exp_reg_data.push_back(wr_val);
			end
			pc = next_pc;
			steps++;
		end
	endtask

	task automatic check_reg_write();
		assert (reg_idx < exp_reg_addr.size()) else begin
			$display("unexpected register write r%0d = %h", reg_write_addr, reg_write_data);
			test_errors++;
		end
		if (reg_idx < exp_reg_addr.size()) begin
			assert (reg_write_addr == exp_reg_addr[reg_idx]) else begin
				$display("mismatch reg_write_addr: got %h, expected %h",
					reg_write_addr, exp_reg_addr[reg_idx]);
				test_errors++;
			end
			assert (reg_write_data == exp_reg_data[reg_idx]) else begin
				$display("mismatch reg_write_data: got %h, expected %h",
					reg_write_data, exp_reg_data[reg_idx]);
				test_errors++;
			end
		end
		reg_idx++;
	endtask

	task automatic check_mem_write();
		assert (mem_idx < exp_mem_addr.size()) else begin
			$display("unexpected memory write at %h with %h", address_dmem, data);
			test_errors++;
		end
		if (mem_idx < exp_mem_addr.size()) begin
			assert (address_dmem == exp_mem_addr[mem_idx]) else begin
				$display("mismatch address_dmem: got %h, expected %h",
					address_dmem, exp_mem_addr[mem_idx]);
				test_errors++;
			end
			assert (data == exp_mem_data[mem_idx]) else begin
				$display("mismatch data: got %h, expected %h", data, exp_mem_data[mem_idx]);
				test_errors++;
			end
		end
		mem_idx++;
	endtask

	// Write strobes are stable at the falling edge
	always @(negedge clock) begin
		if (rst_n) begin
			if (reg_write_en)
				check_reg_write();
			if (wren)
				check_mem_write();
		end
	end

	task automatic start_test();
		@(posedge clock);
		rst_n <= 1'b0;
		@(posedge clock);
		clear_memories();
		for (int i = 0; i < 64; i++)
			prog[i] = enc_j(OP_J, i);
		prog_len = 0;
		exp_reg_addr.delete();
		exp_reg_data.delete();
		exp_mem_addr.delete();
		exp_mem_data.delete();
		reg_idx = 0;
		mem_idx = 0;
		test_errors = 0;
	endtask

	task automatic run_program(input string name);
		int idle;
		int seen;
		run_reference();
		for (int i = 0; i < 64; i++)
			imem[i] <= prog[i];
		repeat (3) @(posedge clock);  // Reset low for 4 edges in all
		rst_n <= 1'b1;
		idle = 0;
		seen = 0;
		while ((reg_idx < exp_reg_addr.size() || mem_idx < exp_mem_addr.size()) &&
			idle < IDLE_LIMIT) begin
			@(posedge clock);
			if (reg_idx + mem_idx == seen) begin
				idle++;
			end else begin
				idle = 0;
				seen = reg_idx + mem_idx;
			end
		end
		repeat (5) @(posedge clock);  // Catches stray writes from flushed slots
		assert (reg_idx >= exp_reg_addr.size()) else begin
			$display("%s: only %0d of %0d register writes seen", name, reg_idx,
				exp_reg_addr.size());
			test_errors++;
		end
		assert (mem_idx >= exp_mem_addr.size()) else begin
			$display("%s: only %0d of %0d memory writes seen", name, mem_idx,
				exp_mem_addr.size());
			test_errors++;
		end
		if (test_errors == 0) begin
			$display("%-12s ok", name);
		end else begin
			$display("%-12s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	task automatic test_alu_chain();
		start_test();
		emit(enc_i(OP_ADDI, 1, 0, 13));
		emit(enc_i(OP_ADDI, 2, 0, -6));
		emit(enc_r(3, 1, 2, 0, ALU_ADD));  // r2 from memory stage, r1 from writeback
		emit(enc_r(4, 3, 1, 0, ALU_SUB));
		emit(enc_r(5, 4, 3, 0, ALU_AND));
		emit(enc_r(6, 5, 2, 0, ALU_OR));
		emit(enc_r(7, 6, 0, 3, ALU_SLL));
		emit(enc_r(8, 7, 0, 2, ALU_SRA));  // Negative operand
		emit(enc_r(9, 8, 1, 0, ALU_SUB));
		emit_halt();
		run_program("alu_chain");
	endtask

	task automatic test_load_store();
		start_test();
		emit(enc_i(OP_ADDI, 1, 0, 20));
		emit(enc_i(OP_ADDI, 2, 0, 32'h1234));
		emit(enc_i(OP_SW, 2, 1, 4));
		emit(enc_i(OP_LW, 3, 1, 4));
		emit(enc_r(4, 3, 2, 0, ALU_ADD));  // Load-use stall
		emit(enc_i(OP_LW, 5, 0, 7));
		emit(enc_i(OP_SW, 5, 1, 0));  // Store data from the load
		emit(enc_r(6, 5, 5, 0, ALU_ADD));
		emit_halt();
		run_program("load_store");
	endtask

	task automatic test_branches();
		start_test();
		emit(enc_i(OP_ADDI, 1, 0, 5));
		emit(enc_i(OP_ADDI, 2, 0, -3));
		emit(enc_i(OP_BNE, 1, 1, 2));  // Not taken
		emit(enc_i(OP_ADDI, 3, 0, 1));
		emit(enc_i(OP_BNE, 1, 2, 2));  // Taken
		emit(enc_i(OP_ADDI, 4, 0, 99));
		emit(enc_i(OP_ADDI, 5, 0, 98));
		emit(enc_i(OP_BLT, 2, 1, 2));  // -3 < 5, taken
		emit(enc_i(OP_ADDI, 6, 0, 97));
		emit(enc_i(OP_ADDI, 7, 0, 96));
		emit(enc_i(OP_BLT, 1, 2, 1));  // Not taken
		emit(enc_i(OP_ADDI, 8, 0, 7));
		emit(enc_i(OP_ADDI, 9, 0, 3));
		emit(enc_i(OP_ADDI, 9, 9, -1));  // Backward loop, three passes
		emit(enc_i(OP_BNE, 9, 0, -2));
		emit_halt();
		run_program("branches");
	endtask

	task automatic test_jumps();
		start_test();
		emit(enc_i(OP_ADDI, 1, 0, 1));
		emit(enc_j(OP_JAL, 5));
		emit(enc_i(OP_ADDI, 2, 0, 2));  // Return point
		emit(enc_j(OP_J, 8));
		emit(enc_i(OP_ADDI, 3, 0, 3));
		emit(enc_i(OP_ADDI, 4, 0, 4));  // Subroutine at word 5
		emit(enc_i(OP_JR, 31, 0, 0));
		emit(enc_i(OP_ADDI, 5, 0, 5));
		emit_halt();
		run_program("jumps");
	endtask

	task automatic test_r0_write();
		start_test();
		emit(enc_i(OP_ADDI, 0, 0, 55));
		emit(enc_i(OP_ADDI, 1, 0, 9));
		emit(enc_r(0, 1, 1, 0, ALU_ADD));
		emit(enc_r(3, 0, 1, 0, ALU_ADD));  // r0 must not forward
		emit(enc_i(OP_LW, 0, 0, 3));
		emit(enc_r(4, 0, 1, 0, ALU_SUB));
		emit_halt();
		run_program("r0_write");
	endtask

	task automatic test_random_alu();
		logic [31:0] r;
		logic [31:0] imm;
		start_test();
		rng_state = 32'hedd1_44cb;
		for (int i = 0; i < 20; i++) begin
			r = next_random();
			imm = next_random();
			case (r % 3)
				0: emit(enc_i(OP_ADDI, int'(r[7:5]), int'(r[10:8]), int'(imm[16:0])));
				1: emit(enc_r(int'(r[7:5]), int'(r[10:8]), int'(r[13:11]), 0, ALU_ADD));
				default: emit(enc_r(int'(r[7:5]), int'(r[10:8]), int'(r[13:11]), 0, ALU_SUB));
			endcase
		end
		emit_halt();
		run_program("random_alu");
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout, run stopped after %0d cycles", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		rng_state = 32'hedd1_44cb;
		prog_len = 0;
		reg_idx = 0;
		mem_idx = 0;
		test_errors = 0;
		total_errors = 0;
		tests_failed = 0;
		clear_memories();
		test_alu_chain();
		test_load_store();
		test_branches();
		test_jumps();
		test_r0_write();
		test_random_alu();
		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
